/* compile.f */
+incdir+src
src/mips_pkg.sv
src/pipeReg.sv
src/mainDecoder.sv
src/regfile.sv
src/alu.sv
src/hazard.sv
src/datapath.sv
dv/datapath_asserts.sv
dv/tb_datapath.sv

/* dv/tb_datapath.sv */
`default_nettype none
`include "mips_defines.svh"

module tb_datapath import mips_pkg::*; ();

    logic                clk;
    logic                rstN;
    logic                dCacheStall;
    logic                instEn;
    logic                memEn;
    logic                storeDone;
    logic [`XLEN/8-1:0]  memWen;
    word_t               instAddr, instr, memAddr, memRdata, memWdata;
    word_t               rom [64];
    word_t               dataRam [16];
    word_t               expAddr [$];
    word_t               expData [$];
    logic [5:0]          functs [5];
    int                  seed, wp, storeIdx, cycles, executed, limit;

    datapath i_dut (
        .clk(clk), .rstN_i(rstN), .instAddrF_o(instAddr), .instEnF_o(instEn),
        .instrF_i(instr), .memEnM_o(memEn), .memAddrM_o(memAddr),
        .memRdataM_i(memRdata), .memWenM_o(memWen), .memWdataM_o(memWdata),
        .dCacheStall_i(dCacheStall)
    );

    always #50 clk = ~clk;

    // combinational rom and ram reads
    assign instr     = rom[instAddr[7:2]];
    assign memRdata  = dataRam[memAddr[5:2]];
    assign storeDone = rstN && memEn && (|memWen) && !dCacheStall;

    always @(posedge clk) begin
        if (storeDone) begin
            dataRam[memAddr[5:2]] <= memWdata;
        end
    end

    function automatic word_t fillWord(input int idx);
        return 32'hDA7A_0000 | (idx << 2);
    endfunction

    function automatic int randBelow(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [4:0] randReg();
        return 5'(1 + randBelow(7));
    endfunction

    function automatic logic [15:0] randAddr();
        return 16'(randBelow(16) * 4);
    endfunction

    function automatic logic [5:0] randFunct();
        return functs[randBelow(5)];
    endfunction

    function automatic word_t encR(input logic [5:0] fn, input logic [4:0] rs,
                                   input logic [4:0] rt, input logic [4:0] rd);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t encI(input logic [5:0] op, input logic [4:0] rs,
                                   input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encJ(input int target);
        return {`OP_J, 26'(target)};
    endfunction

    task automatic emit(input word_t ins);
        rom[wp] = ins;
        wp++;
    endtask

    task automatic buildProgram();
        logic [4:0] dst, srcA, srcB, ld;
        wp = 0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = '0;
        end
        // odd registers sign extended, even ones zero extended with bit 15 set
        for (int r = 1; r < 8; r++) begin
            if (r % 2) begin
                emit(encI(`OP_ADDIU, 5'd0, 5'(r), 16'($random(seed))));
            end else begin
                emit(encI(`OP_ORI, 5'd0, 5'(r), 16'($random(seed)) | 16'h8000));
            end
        end
        for (int k = 0; k < 3; k++) begin
            dst  = randReg();
            srcA = randReg();
            srcB = randReg();
            emit(encR(randFunct(), srcA, srcB, dst));
            srcB = randReg();
            emit(encR(randFunct(), dst, srcB, srcA));
            emit(encI(`OP_SW, 5'd0, srcA, randAddr()));
            ld = randReg();
            emit(encI(`OP_LW, 5'd0, ld, randAddr()));
            emit(encI(`OP_ADDIU, ld, ld, 16'($random(seed))));
            emit(encI(`OP_SW, 5'd0, ld, randAddr()));
        end
        emit(encI(`OP_ORI, 5'd0, 5'd8, 16'($random(seed)) | 16'h0001));
        // r8 is nonzero, so not taken
        emit(encI(`OP_BEQ, 5'd8, 5'd0, 16'd2));
        emit(encI(`OP_SW, 5'd0, 5'd8, randAddr()));
        emit(encR(`FN_ADDU, 5'd8, 5'd1, 5'd9));
        emit(encI(`OP_BEQ, 5'd9, 5'd9, 16'd2));
        emit(encI(`OP_SW, 5'd0, 5'd9, randAddr()));
        emit(encI(`OP_SW, 5'd0, 5'd1, randAddr()));
        emit(encI(`OP_SW, 5'd0, 5'd9, randAddr()));
        emit(encJ(wp + 3));
        emit(encI(`OP_SW, 5'd0, 5'd2, randAddr()));
        emit(encI(`OP_ADDIU, 5'd3, 5'd3, 16'h0100));
        emit(encR(`FN_SLT, 5'd1, 5'd2, 5'd10));
        emit(encI(`OP_SW, 5'd0, 5'd10, randAddr()));
        emit(encR(`FN_SUBU, 5'd3, 5'd4, 5'd11));
        emit(encR(`FN_AND, 5'd11, 5'd5, 5'd12));
        emit(encR(`FN_OR, 5'd12, 5'd6, 5'd13));
        emit(encI(`OP_SW, 5'd0, 5'd13, 16'h0020));
        emit(encI(`OP_LW, 5'd0, 5'd14, 16'h0020));
        // loaded value feeds the branch
        emit(encI(`OP_BEQ, 5'd14, 5'd13, 16'd1));
        emit(encI(`OP_SW, 5'd0, 5'd0, 16'h0004));
        emit(encI(`OP_SW, 5'd0, 5'd14, randAddr()));
        emit(encI(`OP_SW, 5'd0, 5'd11, randAddr()));
        emit(encJ(wp));
    endtask

    // ISA interpreter, no delay slots; fills the expected store list
    function automatic int runReference();
        word_t      regs [32];
        word_t      dmem [16];
        word_t      ins, a, b, se, ze, addr;
        logic [4:0] rt, rd;
        int         pc, nextPc, count;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            dmem[i] = fillWord(i);
        end
        pc = 0;
        count = 0;
        // halt is a j onto itself
        while (!(rom[pc][31:26] == `OP_J && rom[pc][25:0] == 26'(pc)) && count < 1000) begin
            ins    = rom[pc];
            a      = regs[ins[25:21]];
            b      = regs[ins[20:16]];
            rt     = ins[20:16];
            rd     = ins[15:11];
            se     = {{16{ins[15]}}, ins[15:0]};
            ze     = {16'h0000, ins[15:0]};
            nextPc = pc + 1;
            case (ins[31:26])
                `OP_RTYPE: begin
                    case (ins[5:0])
                        `FN_ADDU: regs[rd] = a + b;
                        `FN_SUBU: regs[rd] = a - b;
                        `FN_AND:  regs[rd] = a & b;
                        `FN_OR:   regs[rd] = a | b;
                        `FN_SLT:  regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:  ;
                    endcase
                end
                `OP_ADDIU: regs[rt] = a + se;
                `OP_ORI:   regs[rt] = a | ze;
                `OP_LW: begin
                    addr     = a + se;
                    regs[rt] = dmem[addr[5:2]];
                end
                `OP_SW: begin
                    addr = a + se;
                    dmem[addr[5:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                `OP_BEQ: begin
                    if (a == b) begin
                        nextPc = pc + 1 + int'($signed(se));
                    end
                end
                `OP_J:   nextPc = int'(ins[25:0]);
                default: ;
            endcase
            regs[0] = '0;
            pc = nextPc;
            count++;
        end
        return count;
    endfunction

    task automatic compareWord(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    always @(posedge clk) begin
        // fetch is up from the first cycle after reset and pauses with the freeze
        if (!rstN || dCacheStall) begin
            compareWord("instEnF_o", {{(`XLEN-1){1'b0}}, instEn}, '0);
        end else if (cycles == 1) begin
            compareWord("instEnF_o", {{(`XLEN-1){1'b0}}, instEn}, 32'd1);
        end
        if (storeDone) begin
            if (storeIdx >= expAddr.size()) begin
                $display("an extra store to address 0x%08h was seen after the last expected one",
                         memAddr);
                $display("TB FAILED");
                $fatal(1, "unexpected store");
            end else begin
                compareWord("memAddrM_o", memAddr, expAddr[storeIdx]);
                compareWord("memWdataM_o", memWdata, expData[storeIdx]);
                storeIdx++;
            end
        end
    end

    initial begin
        seed        = 22909;
        clk         = 1'b0;
        rstN        = 1'b0;
        dCacheStall = 1'b0;
        storeIdx    = 0;
        cycles      = 0;
        functs      = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_SLT};
        for (int i = 0; i < 16; i++) begin
            dataRam[i] = fillWord(i);
        end
        buildProgram();
        executed = runReference();
        limit    = executed * 8 + 50;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        // about one cycle in five frozen
        while (storeIdx < expAddr.size() && cycles < limit) begin
            @(negedge clk);
            cycles++;
            dCacheStall = (randBelow(5) == 0);
        end
        if (storeIdx == expAddr.size()) begin
            // halt loop spins so a late or repeated store shows up
            repeat (16) begin
                @(negedge clk);
                dCacheStall = (randBelow(5) == 0);
            end
            $display("TB PASSED");
            $finish;
        end else begin
            $display("timeout: only %0d of %0d stores completed within %0d cycles",
                     storeIdx, expAddr.size(), limit);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire

/* dv/datapath_asserts.sv */
`default_nettype none
`include "mips_defines.svh"

module datapath_asserts import mips_pkg::*; (
    input wire                  clk,
    input wire                  rstN_i,
    input wire                  memEnM_i,
    input wire [`XLEN/8-1:0]    memWenM_i,
    input wire word_t           memAddrM_i,
    input wire word_t           memWdataM_i,
    input wire                  dCacheStall_i
);

    // byte strobes only with an access
    assert property (@(posedge clk) disable iff (!rstN_i)
        (|memWenM_i) |-> memEnM_i)
        else $error("write strobe seen without memory enable");

    assert property (@(posedge clk) disable iff (!rstN_i)
        memEnM_i |-> !$isunknown({memAddrM_i, memWdataM_i}))
        else $error("memory address or write data unknown during an access");

    // frozen pipe keeps the port steady
    assert property (@(posedge clk) disable iff (!rstN_i)
        dCacheStall_i |=> ($stable(memEnM_i) && $stable(memWenM_i)
                           && $stable(memAddrM_i) && $stable(memWdataM_i)))
        else $error("memory port changed while the data cache stalled");

    assert property (@(posedge clk)
        $rose(rstN_i) |-> !memEnM_i)
        else $error("memory enable high right after reset release");

endmodule

bind datapath datapath_asserts i_asserts (
    .clk(clk),
    .rstN_i(rstN_i),
    .memEnM_i(memEnM_o),
    .memWenM_i(memWenM_o),
    .memAddrM_i(memAddrM_o),
    .memWdataM_i(memWdataM_o),
    .dCacheStall_i(dCacheStall_i)
);

`default_nettype wire

/* src/datapath.sv */
`default_nettype none
`include "mips_defines.svh"

module datapath import mips_pkg::*; (
    input  wire                   clk,
    input  wire                   rstN_i,
    output word_t                 instAddrF_o,
    output logic                  instEnF_o,
    input  wire word_t            instrF_i,
    output logic                  memEnM_o,
    output word_t                 memAddrM_o,
    input  wire word_t            memRdataM_i,
    output logic [`XLEN/8-1:0]    memWenM_o,
    output word_t                 memWdataM_o,
    input  wire                   dCacheStall_i
);

    logic     ceF;
    word_t    pcF, pcNext, pcPlus4F;
    logic     stallF, stallD, stallE, stallM, stallW;
    logic     flushD, flushE;
    fwdSel_t  fwdA, fwdB;
    ifId_t    ifIdF, ifIdD;
    ctrl_t    ctrlD;
    regAddr_t rsD, rtD, rdD;
    word_t    rd1D, rd2D, immD, pcPlus4D, pcJumpD;
    idEx_t    idExD, idExE;
    word_t    srcAE, fwdBE, srcBE, aluOutE, pcBranchE;
    logic     zeroE, branchTakenE;
    exMem_t   exMemE, exMemM;
    word_t    resultM;
    memWb_t   memWbM, memWbW;

    function automatic word_t fwdMux(
        input fwdSel_t sel,
        input word_t   regVal,
        input word_t   memVal,
        input word_t   wbVal
    );
        case (sel)
            MEM:     return memVal;
            WB:      return wbVal;
            default: return regVal;
        endcase
    endfunction

    hazard hazard0 (
        .rsE_i(idExE.rs), .rtE_i(idExE.rt), .rsD_i(rsD), .rtD_i(rtD),
        .destM_i(exMemM.dest), .regWriteM_i(exMemM.regWrite),
        .destW_i(memWbW.dest), .regWriteW_i(memWbW.regWrite),
        .memReadE_i(idExE.ctrl.memRead), .branchTakenE_i(branchTakenE),
        .jumpD_i(ctrlD.jump), .dCacheStall_i(dCacheStall_i),
        .fwdA_o(fwdA), .fwdB_o(fwdB),
        .stallF_o(stallF), .stallD_o(stallD), .stallE_o(stallE),
        .stallM_o(stallM), .stallW_o(stallW),
        .flushD_o(flushD), .flushE_o(flushE)
    );

    // fetch enable comes up one cycle after reset
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            ceF <= 1'b0;
        end else begin
            ceF <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pcF <= `RESET_PC;
        end else if (ceF && !stallF) begin
            pcF <= pcNext;
        end
    end

    assign pcPlus4F    = pcF + 4;
    assign pcNext      = branchTakenE ? pcBranchE : ctrlD.jump ? pcJumpD : pcPlus4F;
    assign instAddrF_o = pcF;
    assign instEnF_o   = ceF & ~stallF;
    assign ifIdF       = '{pc: pcF, instr: ceF ? instrF_i : '0};

    pipeReg #(.payload_t(ifId_t)) ifIdReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stallD), .flush_i(flushD),
        .d_i(ifIdF), .q_o(ifIdD)
    );

    assign rsD = ifIdD.instr[25:21];
    assign rtD = ifIdD.instr[20:16];
    assign rdD = ifIdD.instr[15:11];

    mainDecoder mainDecoder0 (.instr_i(ifIdD.instr), .ctrl_o(ctrlD));

    // written from WB, frozen with the pipe
    regfile regfile0 (
        .clk(clk), .rstN_i(rstN_i),
        .we_i(memWbW.regWrite & ~dCacheStall_i),
        .waddr_i(memWbW.dest), .wdata_i(memWbW.result),
        .raddr1_i(rsD), .raddr2_i(rtD),
        .rdata1_o(rd1D), .rdata2_o(rd2D)
    );

    assign immD     = {{(`XLEN-16){ctrlD.signExt & ifIdD.instr[15]}}, ifIdD.instr[15:0]};
    assign pcPlus4D = ifIdD.pc + 4;
    assign pcJumpD  = {pcPlus4D[`XLEN-1 -: 4], ifIdD.instr[25:0], 2'b00};
    assign idExD    = '{ctrl: ctrlD, pc: ifIdD.pc, rs: rsD, rt: rtD,
                        dest: ctrlD.regDstRd ? rdD : rtD,
                        rd1: rd1D, rd2: rd2D, imm: immD};

    pipeReg #(.payload_t(idEx_t)) idExReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stallE), .flush_i(flushE),
        .d_i(idExD), .q_o(idExE)
    );

    assign srcAE = fwdMux(fwdA, idExE.rd1, resultM, memWbW.result);
    // forwarded rt also feeds the store data
    assign fwdBE = fwdMux(fwdB, idExE.rd2, resultM, memWbW.result);
    assign srcBE = idExE.ctrl.aluSrcImm ? idExE.imm : fwdBE;

    alu alu0 (.a_i(srcAE), .b_i(srcBE), .op_i(idExE.ctrl.aluOp),
              .result_o(aluOutE), .zero_o(zeroE));

    assign branchTakenE = idExE.ctrl.branch & zeroE;
    assign pcBranchE    = idExE.pc + 4 + {idExE.imm[`XLEN-3:0], 2'b00};
    assign exMemE       = '{regWrite: idExE.ctrl.regWrite, memRead: idExE.ctrl.memRead,
                            memWrite: idExE.ctrl.memWrite, memToReg: idExE.ctrl.memToReg,
                            dest: idExE.dest, aluOut: aluOutE, storeData: fwdBE};

    pipeReg #(.payload_t(exMem_t)) exMemReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stallM), .flush_i(1'b0),
        .d_i(exMemE), .q_o(exMemM)
    );

    // word accesses only
    assign memEnM_o    = exMemM.memRead | exMemM.memWrite;
    assign memWenM_o   = {(`XLEN/8){exMemM.memWrite}};
    assign memAddrM_o  = exMemM.aluOut;
    assign memWdataM_o = exMemM.storeData;
    assign resultM     = exMemM.memToReg ? memRdataM_i : exMemM.aluOut;
    assign memWbM      = '{regWrite: exMemM.regWrite, dest: exMemM.dest, result: resultM};

    pipeReg #(.payload_t(memWb_t)) memWbReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stallW), .flush_i(1'b0),
        .d_i(memWbM), .q_o(memWbW)
    );

endmodule

`default_nettype wire

/* src/hazard.sv */
`default_nettype none

module hazard import mips_pkg::*; (
    input  wire regAddr_t rsE_i,
    input  wire regAddr_t rtE_i,
    input  wire regAddr_t rsD_i,
    input  wire regAddr_t rtD_i,
    input  wire regAddr_t destM_i,
    input  wire           regWriteM_i,
    input  wire regAddr_t destW_i,
    input  wire           regWriteW_i,
    input  wire           memReadE_i,
    input  wire           branchTakenE_i,
    input  wire           jumpD_i,
    input  wire           dCacheStall_i,
    output fwdSel_t       fwdA_o,
    output fwdSel_t       fwdB_o,
    output logic          stallF_o,
    output logic          stallD_o,
    output logic          stallE_o,
    output logic          stallM_o,
    output logic          stallW_o,
    output logic          flushD_o,
    output logic          flushE_o
);

    logic loadUse;

    // MEM result is younger than WB
    function automatic fwdSel_t fwdFor(
        input regAddr_t src,
        input regAddr_t destM,
        input logic     weM,
        input regAddr_t destW,
        input logic     weW
    );
        if (src != '0 && weM && destM == src) begin
            return MEM;
        end else if (src != '0 && weW && destW == src) begin
            return WB;
        end
        return REG;
    endfunction

    assign fwdA_o = fwdFor(rsE_i, destM_i, regWriteM_i, destW_i, regWriteW_i);
    assign fwdB_o = fwdFor(rtE_i, destM_i, regWriteM_i, destW_i, regWriteW_i);

    // lw writes rt
    assign loadUse = memReadE_i && rtE_i != '0 && (rtE_i == rsD_i || rtE_i == rtD_i);

    assign stallF_o = loadUse | dCacheStall_i;
    assign stallD_o = loadUse | dCacheStall_i;
    assign stallE_o = dCacheStall_i;
    assign stallM_o = dCacheStall_i;
    assign stallW_o = dCacheStall_i;

    // a jump held by a load-use stall must stay in ID until it redirects
    assign flushD_o = (branchTakenE_i | (jumpD_i & ~loadUse)) & ~dCacheStall_i;
    // freeze keeps the EX instruction alive
    assign flushE_o = (branchTakenE_i | loadUse) & ~dCacheStall_i;

endmodule

`default_nettype wire

/* src/alu.sv */
`default_nettype none
`include "mips_defines.svh"

module alu import mips_pkg::*; (
    input  wire word_t  a_i,
    input  wire word_t  b_i,
    input  wire aluOp_t op_i,
    output word_t       result_o,
    output logic        zero_o
);

    logic lessThan;

    // signed compare for slt
    assign lessThan = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ADD:     result_o = a_i + b_i;
            SUB:     result_o = a_i - b_i;
            AND:     result_o = a_i & b_i;
            OR:      result_o = a_i | b_i;
            SLT:     result_o = {{(`XLEN-1){1'b0}}, lessThan};
            default: result_o = '0;
        endcase
    end

    // beq taken when operands are equal
    assign zero_o = (result_o == '0);

endmodule

`default_nettype wire

/* src/regfile.sv */
`default_nettype none
`include "mips_defines.svh"

module regfile import mips_pkg::*; (
    input  wire           clk,
    input  wire           rstN_i,
    input  wire           we_i,
    input  wire regAddr_t waddr_i,
    input  wire word_t    wdata_i,
    input  wire regAddr_t raddr1_i,
    input  wire regAddr_t raddr2_i,
    output word_t         rdata1_o,
    output word_t         rdata2_o
);

    word_t regs [`REG_NUM];

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 reads zero, same-cycle write bypasses the array
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

`default_nettype wire

/* src/mainDecoder.sv */
`default_nettype none
`include "mips_defines.svh"

module mainDecoder import mips_pkg::*; (
    input  wire word_t instr_i,
    output ctrl_t      ctrl_o
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];

    always_comb begin
        ctrl_o = '0;
        case (opcode)
            `OP_RTYPE: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.regDstRd = 1'b1;
                case (funct)
                    `FN_ADDU: ctrl_o.aluOp = ADD;
                    `FN_SUBU: ctrl_o.aluOp = SUB;
                    `FN_AND:  ctrl_o.aluOp = AND;
                    `FN_OR:   ctrl_o.aluOp = OR;
                    `FN_SLT:  ctrl_o.aluOp = SLT;
                    // unsupported funct, nop
                    default:  ctrl_o = '0;
                endcase
            end
            `OP_ADDIU: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.signExt   = 1'b1;
                ctrl_o.aluOp     = ADD;
            end
            `OP_ORI: begin
                // zero-extended imm
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.aluOp     = OR;
            end
            `OP_LW: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.memRead   = 1'b1;
                ctrl_o.memToReg  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.signExt   = 1'b1;
                ctrl_o.aluOp     = ADD;
            end
            `OP_SW: begin
                ctrl_o.memWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.signExt   = 1'b1;
                ctrl_o.aluOp     = ADD;
            end
            `OP_BEQ: begin
                // compare by subtraction
                ctrl_o.branch  = 1'b1;
                ctrl_o.signExt = 1'b1;
                ctrl_o.aluOp   = SUB;
            end
            `OP_J: begin
                ctrl_o.jump = 1'b1;
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/pipeReg.sv */
`default_nettype none

module pipeReg #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           rstN_i,
    input  wire           stall_i,
    input  wire           flush_i,
    input  wire payload_t d_i,
    output payload_t      q_o
);

    // zero payload is a bubble
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* src/mips_pkg.sv */
`default_nettype none
`include "mips_defines.svh"

package mips_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_NUM)-1:0] regAddr_t;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        SLT = 3'd4
    } aluOp_t;

    // EX operand source
    typedef enum logic [1:0] {
        REG = 2'd0,
        MEM = 2'd1,
        WB  = 2'd2
    } fwdSel_t;

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   aluSrcImm;
        logic   signExt;
        logic   regDstRd;
        logic   branch;
        logic   jump;
        aluOp_t aluOp;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } ifId_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    pc;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t dest;
        word_t    rd1;
        word_t    rd2;
        word_t    imm;
    } idEx_t;

    typedef struct packed {
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     memToReg;
        regAddr_t dest;
        word_t    aluOut;
        word_t    storeData;
    } exMem_t;

    typedef struct packed {
        logic     regWrite;
        regAddr_t dest;
        word_t    result;
    } memWb_t;

endpackage

`default_nettype wire

/* src/mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define XLEN     32
`define REG_NUM  32
`define RESET_PC 32'h0000_0000

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_ADDIU 6'h09
`define OP_ORI   6'h0d
`define OP_LW    6'h23
`define OP_SW    6'h2b

// r-type funct codes
`define FN_ADDU  6'h21
`define FN_SUBU  6'h23
`define FN_AND   6'h24
`define FN_OR    6'h25
`define FN_SLT   6'h2a

`endif
